//--- list.f
src/besm_ctl_pkg.sv
src/mode_register.sv
src/cond_select.sv
src/modifier_memory.sv
src/special_registers.sv
src/besm_ctl.sv
test/besm_ctl_checker.sv
test/besm_ctl_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = besm_ctl_tb
FILELIST  = list.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- test/besm_ctl_tb.sv
module besm_ctl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [besm_ctl_pkg::UI_WIDTH-1:0] uw_t;
    typedef struct {
        string       name;
        uw_t         uw;
        logic [63:0] y;
        logic [3:0]  ira;
        logic        valid;
        logic [63:0] exp_d;
        int          exp_c;                        // 0 or 1, NC when unchecked
    } row_t;

    localparam int NC = 2;

    logic        clk, reset, valid, cond, ok;
    uw_t         uinstr;
    logic [63:0] y, d;
    logic [3:0]  ira;
    row_t        rows[$];
    logic        row_valid;                        // Valid for rows being added
    logic [3:0]  row_ira;                          // IRA for rows being added
    int          seed = 32'h4166_8ba0;
    int          n_pass, n_fail, errs;

    besm_ctl besm_ctl_i (
        .clk, .reset, .i_valid(valid), .i_uinstr(uinstr), .i_y(y), .i_ira(ira),
        .o_d(d), .o_condition(cond)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                     // 10 ns period
    end

    initial begin
        #100us;                                    // Watchdog
        $display("Timeout: the simulation ran far past its expected length");
        $display("Result: FAILED");
        $finish;
    end

    //----------------------------------------------------------------------
    // Microinstruction field builders
    //----------------------------------------------------------------------
    function automatic uw_t fld(int lsb, int w, logic [31:0] v);
        uw_t m;
        m = (uw_t'(1) << w) - uw_t'(1);
        return (uw_t'(v) & m) << lsb;
    endfunction

    function automatic uw_t ff(logic [4:0] c);
        return fld(besm_ctl_pkg::FFCNT_LSB, 5, 32'(c));
    endfunction

    function automatic uw_t ds(logic [3:0] c);
        return fld(besm_ctl_pkg::DSRC_LSB, 4, 32'(c));
    endfunction

    function automatic uw_t yd(logic [3:0] c);
        return fld(besm_ctl_pkg::YDST_LSB, 4, 32'(c));
    endfunction

    function automatic uw_t cnd(logic [4:0] c, logic icc);
        return fld(besm_ctl_pkg::COND_LSB, 5, 32'(c)) | fld(besm_ctl_pkg::ICC_BIT, 1, 32'(icc));
    endfunction

    function automatic uw_t mp(logic [4:0] modnm);    // Index from the word, inverted
        return fld(besm_ctl_pkg::MNSA_LSB, 2, 32'(besm_ctl_pkg::MNSA_MP))
             | fld(besm_ctl_pkg::MODNM_LSB, 5, 32'(modnm));
    endfunction

    function automatic void add_row(string n, uw_t w, logic [63:0] yv,
                                    logic [63:0] ed, int ec);
        row_t r;
        r.name  = n;
        r.uw    = w;
        r.y     = yv;
        r.ira   = row_ira;
        r.valid = row_valid;
        r.exp_d = ed;
        r.exp_c = ec;
        rows.push_back(r);
    endfunction

    //----------------------------------------------------------------------
    // Stimulus table, RR tracked in m
    //----------------------------------------------------------------------
    task automatic build_table();
        logic [63:0] r1, r2, r3, r4, r5, r6, r7, r8, r9, r10;
        logic [31:0] m;
        logic [4:0]  mn, k;
        uw_t         cs, we, md, ise;
        r1 = {$random(seed), $random(seed)};
        r2 = {$random(seed), $random(seed)};
        r3 = {$random(seed), $random(seed)};
        r4 = {$random(seed), $random(seed)};
        r5 = {$random(seed), $random(seed)};
        r6 = {$random(seed), $random(seed)};
        r7 = {$random(seed), $random(seed)};
        r8 = {$random(seed), $random(seed)};
        r9 = {$random(seed), $random(seed)};
        r10 = {$random(seed), $random(seed)};
        mn = 5'($random(seed));
        k  = ~mn;                                  // Real modifier index
        r1[28]  = 1'b1;                            // rcb set, so the tkk copy shows
        r1[4:2] = 3'b000;                          // No group yet
        cs  = fld(besm_ctl_pkg::CSM_BIT, 1, 32'd1);
        we  = fld(besm_ctl_pkg::WEM_BIT, 1, 32'd1);
        md  = fld(besm_ctl_pkg::MOD_BIT, 1, 32'd1);
        ise = fld(besm_ctl_pkg::ISE_BIT, 1, 32'd1);
        m   = r1[31:0];
        row_valid = 1'b1;
        row_ira   = 4'd0;
        add_row("rr_load", yd(besm_ctl_pkg::YDST_RR) | cnd(besm_ctl_pkg::COND_YES, 1), r1, '0, 1);
        add_row("grp_add", ff(besm_ctl_pkg::FF_ADDGRP) | ds(besm_ctl_pkg::DSRC_RR), '0,
                {32'b0, m}, NC);
        m[4:2] = 3'b100;                           // grp one-hot
        add_row("set_jmp", ff(besm_ctl_pkg::FF_SETJMP) | ds(besm_ctl_pkg::DSRC_RR), '0,
                {32'b0, m}, NC);
        m[29] = 1'b1;                              // flag_jump
        add_row("clrcb_wins", ff(besm_ctl_pkg::FF_SETC) | ds(besm_ctl_pkg::DSRC_RR)
                | fld(besm_ctl_pkg::DDEV_LSB, 3, 32'(besm_ctl_pkg::DDEV_CLRCB)), '0, {32'b0, m}, NC);
        m[27] = 1'b0;                              // cb
        add_row("clr_jmp", ff(besm_ctl_pkg::FF_CLRJMP) | cnd(besm_ctl_pkg::COND_CB, 1)
                | ds(besm_ctl_pkg::DSRC_RR), '0, {32'b0, m}, 0);
        m[29] = 1'b0;
        add_row("log_grp", ff(besm_ctl_pkg::FF_LOGGRP) | ds(besm_ctl_pkg::DSRC_RR), '0,
                {32'b0, m}, NC);
        m[4:2] = 3'b001;
        add_row("set_tr0", ff(besm_ctl_pkg::FF_SETTR0) | cnd(besm_ctl_pkg::COND_TR0, 1), '0, '0, 0);
        add_row("tr0_inv", ff(besm_ctl_pkg::FF_SETTR1) | cnd(besm_ctl_pkg::COND_TR0, 0), '0, '0, 0);
        add_row("tr1_set", ff(besm_ctl_pkg::FF_SETTKK) | cnd(besm_ctl_pkg::COND_TR1, 1), '0, '0, 1);
        add_row("tkk_set", ff(besm_ctl_pkg::FF_CHTKK) | cnd(besm_ctl_pkg::COND_TKK, 1), '0, '0, 1);
        add_row("tkk_flip", ff(besm_ctl_pkg::FF_SETER) | cnd(besm_ctl_pkg::COND_TKK, 0), '0, '0, 1);
        add_row("emul_ise", ff(besm_ctl_pkg::FF_SETTKK) | ise | cnd(besm_ctl_pkg::COND_EMLRG, 1),
                '0, '0, 1);
        m[28] = 1'b0;                              // rcb took tkk, which was clear
        add_row("rcb_copy", cnd(besm_ctl_pkg::COND_RCB, 0) | ds(besm_ctl_pkg::DSRC_RR), '0,
                {32'b0, m}, 1);
        add_row("undef_cond", cnd(5'd25, 1) | yd(besm_ctl_pkg::YDST_MODGN), r2, '0, 1);
        add_row("modgn_read", yd(besm_ctl_pkg::YDST_PROCN) | ds(besm_ctl_pkg::DSRC_MODGN), r3,
                64'({1'b1, r2[9:5], 5'b0}), NC);
        add_row("procn_read", yd(besm_ctl_pkg::YDST_PHYSPG) | ds(besm_ctl_pkg::DSRC_PROCN), r4,
                64'(r3[7:0]), NC);
        add_row("physpg_read", mp(mn) | cs | we | ds(besm_ctl_pkg::DSRC_PHYSPG), r5,
                64'({r4[19:10], 10'b0}), NC);
        add_row("ureg_load", yd(besm_ctl_pkg::YDST_UREG), 64'(k), '0, NC);
        add_row("ureg_read", cs | md, '0, 64'(r5[31:0]), NC);  // MNSA 0 selects UREG
        add_row("mp_write0", mp(5'h1f) | cs | we, r6, '0, NC);
        add_row("ureg0_load", yd(besm_ctl_pkg::YDST_UREG), '0, '0, NC);
        add_row("ureg0_write", cs | we, r7, '0, NC);           // Blocked, M0
        add_row("ureg0_read", cs, '0, 64'(r6[31:0]), NC);
        add_row("mp_write20", mp(~5'd20) | cs | we, r8, '0, NC);
        add_row("ureg20_load", yd(besm_ctl_pkg::YDST_UREG), 64'd20, '0, NC);
        add_row("ureg20_nomod", cs, '0, '0, NC);               // Privileged index
        add_row("mp_write6", mp(~5'd6) | cs | we, r10, '0, NC);
        row_ira = 4'd6;
        add_row("ira_read", fld(besm_ctl_pkg::MNSA_LSB, 2, 32'(besm_ctl_pkg::MNSA_IRA)) | cs,
                '0, 64'(r10[31:0]), NC);                       // Index from IRA
        row_ira = 4'd0;
        row_valid = 1'b0;
        add_row("hold_rr", yd(besm_ctl_pkg::YDST_RR) | ff(besm_ctl_pkg::FF_SETJMP), r9, '0, NC);
        add_row("hold_procn", yd(besm_ctl_pkg::YDST_PROCN) | ds(besm_ctl_pkg::DSRC_RR), r9,
                {32'b0, m}, NC);
        row_valid = 1'b1;
        add_row("procn_kept", ds(besm_ctl_pkg::DSRC_PROCN), '0, 64'(r3[7:0]), NC);
    endtask

    // Idle outputs after reset, bounded by its own count
    task automatic wait_ready(output logic ready);
        ready = 1'b0;
        for (int n = 0; n < 20 && !ready; n++) begin
            @(negedge clk);
            if (d === '0 && cond === uinstr[besm_ctl_pkg::ICC_BIT])
                ready = 1'b1;
        end
    endtask

    initial begin
        valid  = 1'b0;
        uinstr = '0;
        y      = '0;
        ira    = '0;
        reset  = 1'b1;
        n_pass = 0;
        n_fail = 0;
        build_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        wait_ready(ok);
        if (!ok) begin
            $display("Outputs did not reach their idle values after reset");
            $display("Result: FAILED");
        end else begin
            for (int i = 0; i < rows.size(); i++) begin
                @(posedge clk);
                valid  <= rows[i].valid;
                uinstr <= rows[i].uw;
                y      <= rows[i].y;
                ira    <= rows[i].ira;
                @(negedge clk);                    // Combinational outputs settled
                errs = 0;
                assert (d === rows[i].exp_d) else begin
                    $display("** Error %s: o_d expected %h actual %h",
                             rows[i].name, rows[i].exp_d, d);
                    errs++;
                end
                assert (rows[i].exp_c == NC || cond === rows[i].exp_c[0]) else begin
                    $display("** Error %s: o_condition expected %0d actual %0d",
                             rows[i].name, rows[i].exp_c, cond);
                    errs++;
                end
                if (errs == 0) begin
                    n_pass++;
                    $display("ok   %s", rows[i].name);
                end else
                    n_fail++;
            end
            $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
            if (n_fail == 0)
                $display("Result: PASSED");
            else
                $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- test/besm_ctl_checker.sv
module besm_ctl_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   i_valid,
    input logic [3:0]             i_ydst,
    input logic [31:0]            i_y_low,
    input logic                   i_iomp,
    input logic [4:0]             i_ffcnt,
    input logic [2:0]             i_ddev,
    input logic                   i_ise,
    input besm_ctl_pkg::rr_word_t o_rr,
    input logic                   o_tr0,
    input logic                   o_tkk
);
    timeunit 1ns;
    timeprecision 100ps;

    // Plain load only, no trigger, cb clear or rcb copy in the same word
    a_rr_load: assert property (@(posedge clk) disable iff (reset)
        (i_valid && i_ydst == besm_ctl_pkg::YDST_RR && (i_iomp || i_ffcnt == '0)
         && i_ddev != besm_ctl_pkg::DDEV_CLRCB && !i_ise)
        |=> o_rr.raw == $past(i_y_low))
        else $error("RR does not hold the Y low word after a load");

    a_set_tr0: assert property (@(posedge clk) disable iff (reset)
        (i_valid && !i_iomp && i_ffcnt == besm_ctl_pkg::FF_SETTR0) |=> o_tr0)
        else $error("tr0 not set by its trigger");

    a_ise_rcb: assert property (@(posedge clk) disable iff (reset)
        (i_valid && i_ise) |=> o_rr.bits.rcb == $past(o_tkk))   // rcb follows old tkk
        else $error("rcb did not take the previous tkk");

endmodule

bind mode_register besm_ctl_checker besm_ctl_checker_i (
    .clk(clk), .reset(reset), .i_valid(i_valid), .i_ydst(i_ydst), .i_y_low(i_y_low),
    .i_iomp(i_iomp), .i_ffcnt(i_ffcnt), .i_ddev(i_ddev), .i_ise(i_ise),
    .o_rr(o_rr), .o_tr0(o_tr0), .o_tkk(o_tkk)
);

//--- src/besm_ctl.sv
module besm_ctl (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_valid,
    input  logic [besm_ctl_pkg::UI_WIDTH-1:0] i_uinstr,
    input  logic [besm_ctl_pkg::Y_WIDTH-1:0]  i_y,
    input  logic [3:0]                        i_ira,
    output logic [besm_ctl_pkg::Y_WIDTH-1:0]  o_d,
    output logic                              o_condition
);

    // Microinstruction fields
    logic [besm_ctl_pkg::COND_W-1:0]  cond;
    logic [besm_ctl_pkg::FFCNT_W-1:0] ffcnt;
    logic [besm_ctl_pkg::DDEV_W-1:0]  ddev;
    logic [besm_ctl_pkg::YDST_W-1:0]  ydst;
    logic [besm_ctl_pkg::DSRC_W-1:0]  dsrc;
    logic [besm_ctl_pkg::MODNM_W-1:0] modnm;
    logic [besm_ctl_pkg::MNSA_W-1:0]  mnsa;

    // Between units
    besm_ctl_pkg::rr_word_t                rr;
    logic                                  tr0, tr1, tkk, besm6_mode;
    logic [besm_ctl_pkg::MODGN_WIDTH-1:0]  modgn;
    logic [31:0]                           ureg;
    logic [besm_ctl_pkg::MR_WIDTH-1:0]     mr_data;
    logic                                  mr_rd_en;

    assign cond  = i_uinstr[besm_ctl_pkg::COND_LSB  +: besm_ctl_pkg::COND_W];
    assign ffcnt = i_uinstr[besm_ctl_pkg::FFCNT_LSB +: besm_ctl_pkg::FFCNT_W];
    assign ddev  = i_uinstr[besm_ctl_pkg::DDEV_LSB  +: besm_ctl_pkg::DDEV_W];
    assign ydst  = i_uinstr[besm_ctl_pkg::YDST_LSB  +: besm_ctl_pkg::YDST_W];
    assign dsrc  = i_uinstr[besm_ctl_pkg::DSRC_LSB  +: besm_ctl_pkg::DSRC_W];
    assign modnm = i_uinstr[besm_ctl_pkg::MODNM_LSB +: besm_ctl_pkg::MODNM_W];
    assign mnsa  = i_uinstr[besm_ctl_pkg::MNSA_LSB  +: besm_ctl_pkg::MNSA_W];

    mode_register mode_register_i (
        .clk, .reset, .i_valid,
        .i_ydst       (ydst),
        .i_y_low      (i_y[31:0]),
        .i_iomp       (i_uinstr[besm_ctl_pkg::IOMP_BIT]),
        .i_ffcnt      (ffcnt),
        .i_ddev       (ddev),
        .i_ise        (i_uinstr[besm_ctl_pkg::ISE_BIT]),
        .o_rr         (rr),
        .o_tr0        (tr0),
        .o_tr1        (tr1),
        .o_tkk        (tkk),
        .o_besm6_mode (besm6_mode)
    );

    cond_select cond_select_i (
        .i_cond       (cond),
        .i_icc        (i_uinstr[besm_ctl_pkg::ICC_BIT]),
        .i_rr         (rr),
        .i_tr0        (tr0),
        .i_tr1        (tr1),
        .i_tkk        (tkk),
        .i_besm6_mode (besm6_mode),
        .o_condition
    );

    modifier_memory modifier_memory_i (
        .clk, .i_valid,
        .i_csm      (i_uinstr[besm_ctl_pkg::CSM_BIT]),
        .i_wem      (i_uinstr[besm_ctl_pkg::WEM_BIT]),
        .i_mod      (i_uinstr[besm_ctl_pkg::MOD_BIT]),
        .i_mnsa     (mnsa),
        .i_modnm    (modnm),
        .i_ira,
        .i_ureg_low (ureg[besm_ctl_pkg::MODNM_W-1:0]),   // Index from UREG
        .i_modgn    (modgn),
        .i_y_low    (i_y[31:0]),
        .o_mr_data  (mr_data),
        .o_mr_rd_en (mr_rd_en)
    );

    special_registers special_registers_i (
        .clk, .reset, .i_valid,
        .i_ydst     (ydst),
        .i_dsrc     (dsrc),
        .i_y,
        .i_rr       (rr),
        .i_mr_data  (mr_data),
        .i_mr_rd_en (mr_rd_en),
        .o_modgn    (modgn),
        .o_ureg     (ureg),
        .o_d
    );

endmodule

//--- src/special_registers.sv
module special_registers (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 i_valid,
    input  logic [3:0]                           i_ydst,
    input  logic [3:0]                           i_dsrc,
    input  logic [besm_ctl_pkg::Y_WIDTH-1:0]     i_y,
    input  besm_ctl_pkg::rr_word_t               i_rr,
    input  logic [besm_ctl_pkg::MR_WIDTH-1:0]    i_mr_data,
    input  logic                                 i_mr_rd_en,
    output logic [besm_ctl_pkg::MODGN_WIDTH-1:0] o_modgn,
    output logic [31:0]                          o_ureg,
    output logic [besm_ctl_pkg::Y_WIDTH-1:0]     o_d
);

    logic [7:0] procn;                             // Process number
    logic [9:0] physpg;                            // Physical page

    //----------------------------------------------------------------------
    // Registers written from Y
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_modgn <= '0;
            procn   <= '0;
            physpg  <= '0;
            o_ureg  <= '0;
        end else if (i_valid) begin
            case (i_ydst)
                besm_ctl_pkg::YDST_MODGN:  o_modgn <= i_y[9:5];
                besm_ctl_pkg::YDST_PROCN:  procn   <= i_y[7:0];
                besm_ctl_pkg::YDST_PHYSPG: physpg  <= i_y[19:10];
                besm_ctl_pkg::YDST_UREG:   o_ureg  <= i_y[31:0];
                default: ;                         // RR lives in mode_register
            endcase
        end
    end

    //----------------------------------------------------------------------
    // D-bus source select
    //----------------------------------------------------------------------
    always_comb begin
        o_d = '0;
        case (i_dsrc)
            besm_ctl_pkg::DSRC_MODGN:  o_d[10:0]  = {1'b1, o_modgn, 5'b0};
            besm_ctl_pkg::DSRC_PROCN:  o_d[7:0]   = procn;
            besm_ctl_pkg::DSRC_RR:
                o_d[besm_ctl_pkg::RR_WIDTH-1:0] = i_rr.raw;
            besm_ctl_pkg::DSRC_PHYSPG: o_d[19:10] = physpg;
            default: begin
                if (i_mr_rd_en)                    // Modifier read
                    o_d[besm_ctl_pkg::MR_WIDTH-1:0] = i_mr_data;
            end
        endcase
    end

endmodule

//--- src/modifier_memory.sv
module modifier_memory (
    input  logic                                 clk,
    input  logic                                 i_valid,
    input  logic                                 i_csm,
    input  logic                                 i_wem,
    input  logic                                 i_mod,
    input  logic [1:0]                           i_mnsa,
    input  logic [besm_ctl_pkg::MODNM_W-1:0]     i_modnm,
    input  logic [3:0]                           i_ira,
    input  logic [besm_ctl_pkg::MODNM_W-1:0]     i_ureg_low,
    input  logic [besm_ctl_pkg::MODGN_WIDTH-1:0] i_modgn,
    input  logic [31:0]                          i_y_low,
    output logic [besm_ctl_pkg::MR_WIDTH-1:0]    o_mr_data,
    output logic                                 o_mr_rd_en
);

    logic [besm_ctl_pkg::MR_WIDTH-1:0] mem [besm_ctl_pkg::MR_DEPTH];

    logic [besm_ctl_pkg::MODNM_W-1:0] idx;        // Modifier number in group
    logic [besm_ctl_pkg::MODGN_WIDTH+besm_ctl_pkg::MODNM_W-1:0] addr;
    logic mp_sel;                                  // Index from microinstruction
    logic priv_block;                              // Upper half needs privilege
    logic wr_en;

    always_comb begin
        case (i_mnsa)
            besm_ctl_pkg::MNSA_UREG: idx = i_ureg_low;
            besm_ctl_pkg::MNSA_IRA:  idx = {1'b0, i_ira};
            besm_ctl_pkg::MNSA_MP:   idx = ~i_modnm;   // Field holds inverse
            default:                 idx = '0;
        endcase
    end

    assign addr   = {i_modgn, idx};
    assign mp_sel = (i_mnsa == besm_ctl_pkg::MNSA_MP);

    // M16..M31 only with MOD or a microprogram index
    assign priv_block = idx[besm_ctl_pkg::MODNM_W-1] && !mp_sel && !i_mod;

    // M0 is read-only unless addressed by the microprogram
    assign wr_en = i_valid && i_csm && i_wem && !priv_block
                   && !(idx == '0 && !mp_sel);

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[addr] <= i_y_low;
    end

    assign o_mr_data  = priv_block ? '0 : mem[addr];
    assign o_mr_rd_en = i_csm && !i_wem;

endmodule

//--- src/cond_select.sv
module cond_select (
    input  logic [4:0]             i_cond,
    input  logic                   i_icc,
    input  besm_ctl_pkg::rr_word_t i_rr,
    input  logic                   i_tr0,
    input  logic                   i_tr1,
    input  logic                   i_tkk,
    input  logic                   i_besm6_mode,
    output logic                   o_condition
);

    logic cond_mux;                                // Selected condition

    always_comb begin
        case (i_cond)
            besm_ctl_pkg::COND_NORMB:  cond_mux = i_rr.bits.normb;
            besm_ctl_pkg::COND_RNDB:   cond_mux = i_rr.bits.rndb;
            besm_ctl_pkg::COND_OVRIB:  cond_mux = i_rr.bits.ovrib;
            besm_ctl_pkg::COND_BNB:    cond_mux = i_rr.bits.bnb;
            besm_ctl_pkg::COND_OVRFTB: cond_mux = i_rr.bits.ovrftb;
            besm_ctl_pkg::COND_DRG:    cond_mux = i_rr.bits.drg;
            besm_ctl_pkg::COND_EMLRG:  cond_mux = i_besm6_mode;
            besm_ctl_pkg::COND_RCB:    cond_mux = i_rr.bits.rcb;
            besm_ctl_pkg::COND_CB:     cond_mux = i_rr.bits.cb;
            besm_ctl_pkg::COND_CEMLRG: cond_mux = i_rr.bits.cemlrg;
            besm_ctl_pkg::COND_TR1:    cond_mux = i_tr1;
            besm_ctl_pkg::COND_INTSTP: cond_mux = i_rr.bits.intstp;
            besm_ctl_pkg::COND_TKK:    cond_mux = i_tkk;
            besm_ctl_pkg::COND_TR0:    cond_mux = i_tr0;
            // No ALU status or decoder in this block
            besm_ctl_pkg::COND_YES,
            besm_ctl_pkg::COND_CT,
            besm_ctl_pkg::COND_IR15:   cond_mux = 1'b1;
            default:                   cond_mux = 1'b1; // Undefined codes
        endcase
    end

    // ICC set passes the condition, clear inverts it
    assign o_condition = i_icc ? cond_mux : ~cond_mux;

endmodule

//--- src/mode_register.sv
module mode_register (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_valid,
    input  logic [3:0]             i_ydst,
    input  logic [31:0]            i_y_low,
    input  logic                   i_iomp,
    input  logic [4:0]             i_ffcnt,
    input  logic [2:0]             i_ddev,
    input  logic                   i_ise,
    output besm_ctl_pkg::rr_word_t o_rr,
    output logic                   o_tr0,
    output logic                   o_tr1,
    output logic                   o_tkk,
    output logic                   o_besm6_mode
);

    logic ff_en;                                   // Flag decoder selected

    assign ff_en = !i_iomp;

    // Later assignments win, so triggers override a load from Y
    always_ff @(posedge clk) begin
        if (reset) begin
            o_rr         <= '0;
            o_tr0        <= 1'b0;
            o_tr1        <= 1'b0;
            o_tkk        <= 1'b0;
            o_besm6_mode <= 1'b0;                  // Native mode after reset
        end else if (i_valid) begin
            if (i_ydst == besm_ctl_pkg::YDST_RR)
                o_rr.raw <= i_y_low;               // Whole word from Y

            if (ff_en) begin
                case (i_ffcnt)
                    besm_ctl_pkg::FF_LOGGRP: o_rr.bits.grp       <= 3'b001;
                    besm_ctl_pkg::FF_MULGRP: o_rr.bits.grp       <= 3'b010;
                    besm_ctl_pkg::FF_ADDGRP: o_rr.bits.grp       <= 3'b100;
                    besm_ctl_pkg::FF_CLRJMP: o_rr.bits.flag_jump <= 1'b0;
                    besm_ctl_pkg::FF_SETJMP: o_rr.bits.flag_jump <= 1'b1;
                    besm_ctl_pkg::FF_SETEI:  o_rr.bits.no_intr   <= 1'b0;
                    besm_ctl_pkg::FF_CLREI:  o_rr.bits.no_intr   <= 1'b1;
                    besm_ctl_pkg::FF_CLRTR0: o_tr0               <= 1'b0;
                    besm_ctl_pkg::FF_SETTR0: o_tr0               <= 1'b1;
                    besm_ctl_pkg::FF_CLRTR1: o_tr1               <= 1'b0;
                    besm_ctl_pkg::FF_SETTR1: o_tr1               <= 1'b1;
                    besm_ctl_pkg::FF_CLRTKK: o_tkk               <= 1'b0;
                    besm_ctl_pkg::FF_SETTKK: o_tkk               <= 1'b1;
                    besm_ctl_pkg::FF_SETNR:  o_besm6_mode        <= 1'b0;
                    besm_ctl_pkg::FF_SETER:  o_besm6_mode        <= 1'b1;
                    besm_ctl_pkg::FF_CHTKK:  o_tkk               <= ~o_tkk; // Toggle
                    default: ;                     // cb and rcb handled below
                endcase
            end

            // cb has its own clear path from the D-bus device field
            if (i_ddev == besm_ctl_pkg::DDEV_CLRCB)
                o_rr.bits.cb <= 1'b0;              // Clear beats set
            else if (ff_en && i_ffcnt == besm_ctl_pkg::FF_SETC)
                o_rr.bits.cb <= 1'b1;

            if (i_ise)
                o_rr.bits.rcb <= o_tkk;            // Copy standardizer flag
            else if (ff_en && i_ffcnt == besm_ctl_pkg::FF_CLRRCB)
                o_rr.bits.rcb <= 1'b0;
            else if (ff_en && i_ffcnt == besm_ctl_pkg::FF_SETRCB)
                o_rr.bits.rcb <= 1'b1;
        end
    end

endmodule

//--- src/besm_ctl_pkg.sv
package besm_ctl_pkg;

    //----------------------------------------------------------------------
    // Word sizes
    //----------------------------------------------------------------------
    localparam int UI_WIDTH    = 112;         // Microinstruction word
    localparam int Y_WIDTH     = 64;          // Y and D buses
    localparam int RR_WIDTH    = 32;          // Mode register
    localparam int MR_DEPTH    = 1024;        // 32 groups of 32 modifiers
    localparam int MR_WIDTH    = 32;
    localparam int MODGN_WIDTH = 5;           // Modifier group number

    //----------------------------------------------------------------------
    // Microinstruction field positions
    //----------------------------------------------------------------------
    localparam int COND_LSB  = 2;             // Condition select
    localparam int COND_W    = 5;
    localparam int FFCNT_LSB = 7;             // Flag trigger control
    localparam int FFCNT_W   = 5;
    localparam int IOMP_BIT  = 12;            // Low selects flag decoder
    localparam int DDEV_LSB  = 14;            // D-bus device
    localparam int DDEV_W    = 3;
    localparam int WEM_BIT   = 29;            // Modifier write enable
    localparam int CSM_BIT   = 30;            // Modifier memory access
    localparam int ISE_BIT   = 33;
    localparam int ICC_BIT   = 34;            // Condition polarity
    localparam int YDST_LSB  = 48;            // Y-bus destination
    localparam int YDST_W    = 4;
    localparam int DSRC_LSB  = 52;            // D-bus source
    localparam int DSRC_W    = 4;
    localparam int MODNM_LSB = 56;            // Modifier number, inverted
    localparam int MODNM_W   = 5;
    localparam int MNSA_LSB  = 61;            // Modifier index source
    localparam int MNSA_W    = 2;
    localparam int MOD_BIT   = 63;            // Privileged access

    // Y destinations and D sources
    localparam logic [3:0] YDST_MODGN  = 4'd1;
    localparam logic [3:0] YDST_PROCN  = 4'd2;
    localparam logic [3:0] YDST_RR     = 4'd3;
    localparam logic [3:0] YDST_PHYSPG = 4'd4;
    localparam logic [3:0] YDST_UREG   = 4'd8;
    localparam logic [3:0] DSRC_MODGN  = 4'd1;
    localparam logic [3:0] DSRC_PROCN  = 4'd2;
    localparam logic [3:0] DSRC_RR     = 4'd3;
    localparam logic [3:0] DSRC_PHYSPG = 4'd4;

    //----------------------------------------------------------------------
    // Flag trigger codes
    //----------------------------------------------------------------------
    localparam logic [4:0] FF_LOGGRP = 5'd1;
    localparam logic [4:0] FF_MULGRP = 5'd2;
    localparam logic [4:0] FF_ADDGRP = 5'd3;
    localparam logic [4:0] FF_SETC   = 5'd5;
    localparam logic [4:0] FF_CLRRCB = 5'd6;
    localparam logic [4:0] FF_SETRCB = 5'd7;
    localparam logic [4:0] FF_CLRJMP = 5'd8;
    localparam logic [4:0] FF_SETJMP = 5'd9;
    localparam logic [4:0] FF_SETEI  = 5'd10;  // Unmask interrupts
    localparam logic [4:0] FF_CLREI  = 5'd11;
    localparam logic [4:0] FF_CLRTR0 = 5'd12;
    localparam logic [4:0] FF_SETTR0 = 5'd13;
    localparam logic [4:0] FF_CLRTR1 = 5'd14;
    localparam logic [4:0] FF_SETTR1 = 5'd15;
    localparam logic [4:0] FF_CLRTKK = 5'd18;
    localparam logic [4:0] FF_SETTKK = 5'd19;
    localparam logic [4:0] FF_SETNR  = 5'd20;  // Native mode
    localparam logic [4:0] FF_SETER  = 5'd22;  // Emulation mode
    localparam logic [4:0] FF_CHTKK  = 5'd23;
    localparam logic [2:0] DDEV_CLRCB = 3'd3;

    // Condition codes
    localparam logic [4:0] COND_YES    = 5'd0;
    localparam logic [4:0] COND_NORMB  = 5'd1;
    localparam logic [4:0] COND_RNDB   = 5'd2;
    localparam logic [4:0] COND_OVRIB  = 5'd3;
    localparam logic [4:0] COND_BNB    = 5'd4;
    localparam logic [4:0] COND_OVRFTB = 5'd5;
    localparam logic [4:0] COND_DRG    = 5'd6;
    localparam logic [4:0] COND_EMLRG  = 5'd7;
    localparam logic [4:0] COND_RCB    = 5'd8;
    localparam logic [4:0] COND_CB     = 5'd9;
    localparam logic [4:0] COND_CEMLRG = 5'd10;
    localparam logic [4:0] COND_CT     = 5'd11;
    localparam logic [4:0] COND_TR1    = 5'd12;
    localparam logic [4:0] COND_INTSTP = 5'd13;
    localparam logic [4:0] COND_IR15   = 5'd14;
    localparam logic [4:0] COND_TKK    = 5'd15;
    localparam logic [4:0] COND_TR0    = 5'd22;

    // Modifier index sources
    localparam logic [1:0] MNSA_UREG = 2'd0;
    localparam logic [1:0] MNSA_IRA  = 2'd1;
    localparam logic [1:0] MNSA_MP   = 2'd3;

    // Mode register, seen whole or bit by bit
    typedef union packed {
        logic [RR_WIDTH-1:0] raw;
        struct packed {
            logic [1:0] unused;
            logic       flag_jump;        // Jump instruction flag
            logic       rcb;              // Right instruction flag
            logic       cb;               // Address modified by reg 16
            logic       no_paging;
            logic       no_procnm;
            logic       flag_negaddr;
            logic       no_rprot;
            logic       no_wprot;
            logic       intstp;           // Stop on interrupt
            logic       single_step;
            logic       cemlrg;
            logic       no_wtag;
            logic       no_intr;          // External interrupt mask
            logic       no_progtag;
            logic       no_badacc;
            logic       no_rtag;
            logic       no_badop;
            logic       drg;              // Dispatcher mode
            logic       ovrftb;
            logic       bnb;
            logic       flag_z;
            logic       flag_n;
            logic       flag_c;
            logic       flag_v;
            logic       ovrib;
            logic [2:0] grp;              // Branch group, one-hot
            logic       rndb;             // Rounding lock
            logic       normb;            // Normalization lock
        } bits;
    } rr_word_t;

endpackage
